/* bench/ooo_core_tb.sv */
module ooo_core_tb;

    localparam int DEPTH = 8;
    // tests need about 400 cycles, the limit leaves a wide margin
    localparam int TIMEOUT_CYCLES = 2000;

    localparam logic [1:0] KIND_ALU    = 2'd0;
    localparam logic [1:0] KIND_STORE  = 2'd1;
    localparam logic [1:0] KIND_BRANCH = 2'd2;

    // expected retirement of one accepted instruction
    typedef struct packed {
        logic [1:0]         kind;
        logic               mispredict;
        rob_pkg::reg_name_t rd;
        rob_pkg::tag_t      tag;
        rob_pkg::data_t     data;
        rob_pkg::addr_t     addr;
    } expect_t;

    logic               clk = 1'b0;
    logic               rst;
    logic               issue_valid;
    op_pkg::op_t        issue_op;
    rob_pkg::reg_name_t issue_rd;
    rob_pkg::data_t     issue_a;
    rob_pkg::data_t     issue_b;
    logic               issue_pred;
    rob_pkg::addr_t     issue_target;
    logic               issue_stall;
    logic               commit_en;
    rob_pkg::reg_name_t commit_rd;
    rob_pkg::data_t     commit_data;
    rob_pkg::tag_t      commit_tag;
    logic               flush;
    rob_pkg::addr_t     flush_pc;
    logic               mem_we;
    rob_pkg::addr_t     mem_addr;
    rob_pkg::data_t     mem_data;

    expect_t exp_q[$];
    int      errors       = 0;
    int      tag_ctr      = 0;
    int      commit_count = 0;
    int      store_count  = 0;
    int      flush_count  = 0;
    int      stall_cycles = 0;
    int      cycle_count  = 0;

    ooo_core #(
        .ROB_DEPTH(DEPTH)
    ) uut (
        .clk         (clk),
        .rst         (rst),
        .issue_valid (issue_valid),
        .issue_op    (issue_op),
        .issue_rd    (issue_rd),
        .issue_a     (issue_a),
        .issue_b     (issue_b),
        .issue_pred  (issue_pred),
        .issue_target(issue_target),
        .issue_stall (issue_stall),
        .commit_en   (commit_en),
        .commit_rd   (commit_rd),
        .commit_data (commit_data),
        .commit_tag  (commit_tag),
        .flush       (flush),
        .flush_pc    (flush_pc),
        .mem_we      (mem_we),
        .mem_addr    (mem_addr),
        .mem_data    (mem_data)
    );

    always #4 clk = ~clk;

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            $display("error at %0t: %s is %h, expected %h", $time, name, got, expected);
            errors++;
        end
    endtask

    function automatic expect_t predict_effect(input op_pkg::op_t op,
                                               input rob_pkg::reg_name_t rd,
                                               input rob_pkg::data_t a,
                                               input rob_pkg::data_t b,
                                               input logic pred,
                                               input rob_pkg::addr_t target,
                                               input rob_pkg::tag_t tag);
        expect_t e;
        logic    taken;
        e      = '0;
        e.rd   = rd;
        e.tag  = tag;
        e.kind = KIND_ALU;
        case (op)
            op_pkg::OP_ADD: e.data = a + b;
            op_pkg::OP_SUB: e.data = a - b;
            op_pkg::OP_XOR: e.data = a ^ b;
            op_pkg::OP_SW: begin
                e.kind = KIND_STORE;
                e.addr = a;
                e.data = b;
            end
            op_pkg::OP_BEQ, op_pkg::OP_BNE: begin
                taken        = (op == op_pkg::OP_BEQ) ? (a == b) : (a != b);
                e.kind       = KIND_BRANCH;
                e.mispredict = pred != taken;
                e.addr       = taken ? target : target + 32'd4;
            end
            default: e.data = '0;
        endcase
        return e;
    endfunction

    // retirement and acceptance are both sampled away from the rising edge
    always @(negedge clk) begin
        expect_t e;
        if (!rst) begin
            if (commit_en || mem_we || flush) begin
                // correctly predicted branches retire without a trace
                while (exp_q.size() > 0 && exp_q[0].kind == KIND_BRANCH && !exp_q[0].mispredict)
                    void'(exp_q.pop_front());
                if (exp_q.size() == 0) begin
                    $display("retirement at %0t with no instruction left to retire", $time);
                    errors++;
                end else begin
                    e = exp_q.pop_front();
                    if (commit_en) begin
                        commit_count++;
                        if (e.kind != KIND_ALU) begin
                            $display("commit_en at %0t for an instruction that is not ALU", $time);
                            errors++;
                        end else begin
                            check_value("commit_rd", 32'(commit_rd), 32'(e.rd));
                            check_value("commit_data", commit_data, e.data);
                            check_value("commit_tag", 32'(commit_tag), 32'(e.tag));
                        end
                    end else if (mem_we) begin
                        store_count++;
                        if (e.kind != KIND_STORE) begin
                            $display("mem_we at %0t while the oldest instruction is no store", $time);
                            errors++;
                        end else begin
                            check_value("mem_addr", mem_addr, e.addr);
                            check_value("mem_data", mem_data, e.data);
                        end
                    end else if (e.kind != KIND_BRANCH || !e.mispredict) begin
                        $display("flush at %0t without a mispredicted branch at the head", $time);
                        errors++;
                    end else begin
                        check_value("flush_pc", flush_pc, e.addr);
                    end
                end
            end
            if (flush) begin
                // younger work is dropped and tags restart at 0
                exp_q.delete();
                tag_ctr = 0;
                flush_count++;
            end
            if (issue_valid && !issue_stall && !flush) begin
                exp_q.push_back(predict_effect(issue_op, issue_rd, issue_a, issue_b, issue_pred,
                                               issue_target, rob_pkg::tag_t'(tag_ctr % DEPTH)));
                tag_ctr++;
            end
            if (issue_stall) begin
                stall_cycles++;
            end
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count == TIMEOUT_CYCLES) begin
            $display("timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Test FAILED");
            $finish;
        end
    end

    // hold the instruction until a cycle without stall
    task automatic issue_one(input op_pkg::op_t op, input rob_pkg::reg_name_t rd,
                             input rob_pkg::data_t a, input rob_pkg::data_t b,
                             input logic pred, input rob_pkg::addr_t target);
        logic held;
        issue_valid  <= 1'b1;
        issue_op     <= op;
        issue_rd     <= rd;
        issue_a      <= a;
        issue_b      <= b;
        issue_pred   <= pred;
        issue_target <= target;
        held = 1'b1;
        while (held) begin
            @(negedge clk);
            held = issue_stall;
            @(posedge clk);
        end
    endtask

    task automatic stop_issue();
        issue_valid <= 1'b0;
    endtask

    task automatic wait_drain();
        while (exp_q.size() != 0)
            @(posedge clk);
    endtask

    function automatic op_pkg::op_t random_alu_op();
        int pick;
        pick = int'($urandom % 3);
        case (pick)
            0:       return op_pkg::OP_ADD;
            1:       return op_pkg::OP_SUB;
            default: return op_pkg::OP_XOR;
        endcase
    endfunction

    task automatic issue_alu();
        issue_one(random_alu_op(), rob_pkg::reg_name_t'($urandom), $urandom, $urandom, 1'b0, '0);
    endtask

    task automatic issue_store();
        issue_one(op_pkg::OP_SW, '0, $urandom & 32'hffff_fffc, $urandom, 1'b0, '0);
    endtask

    task automatic issue_branch(input op_pkg::op_t op, input logic equal, input logic pred);
        rob_pkg::data_t a;
        rob_pkg::addr_t target;
        a      = $urandom;
        target = $urandom & 32'hffff_fffc;
        issue_one(op, '0, a, equal ? a : ~a, pred, target);
    endtask

    task automatic alu_burst(input int n);
        int base;
        base = commit_count;
        for (int i = 0; i < n; i++)
            issue_alu();
        stop_issue();
        wait_drain();
        check_value("commit count", 32'(commit_count - base), 32'(n));
    endtask

    task automatic fill_buffer();
        int stalls;
        int stores;
        int commits;
        stalls  = stall_cycles;
        stores  = store_count;
        commits = commit_count;
        // stores hold the head two cycles each, so the buffer fills up
        for (int i = 0; i < 10; i++)
            issue_store();
        for (int i = 0; i < 6; i++)
            issue_alu();
        stop_issue();
        wait_drain();
        if (stall_cycles == stalls) begin
            $display("issue_stall never rose while the buffer was flooded");
            errors++;
        end
        check_value("store count", 32'(store_count - stores), 32'd10);
        check_value("commit count", 32'(commit_count - commits), 32'd6);
    endtask

    task automatic store_interleave();
        int stores;
        int commits;
        stores  = store_count;
        commits = commit_count;
        for (int i = 0; i < 12; i++) begin
            if (i % 2 == 0)
                issue_store();
            else
                issue_alu();
        end
        stop_issue();
        wait_drain();
        check_value("store count", 32'(store_count - stores), 32'd6);
        check_value("commit count", 32'(commit_count - commits), 32'd6);
    endtask

    task automatic predicted_branches();
        int flushes;
        int commits;
        flushes = flush_count;
        commits = commit_count;
        issue_alu();
        issue_branch(op_pkg::OP_BEQ, 1'b1, 1'b1);
        issue_alu();
        issue_branch(op_pkg::OP_BEQ, 1'b0, 1'b0);
        issue_alu();
        issue_branch(op_pkg::OP_BNE, 1'b0, 1'b1);
        issue_alu();
        issue_branch(op_pkg::OP_BNE, 1'b1, 1'b0);
        issue_alu();
        issue_alu();
        stop_issue();
        wait_drain();
        check_value("flush count", 32'(flush_count - flushes), 32'd0);
        check_value("commit count", 32'(commit_count - commits), 32'd6);
    endtask

    task automatic mispredict_recovery(input op_pkg::op_t op, input logic equal,
                                       input logic pred);
        int flushes;
        int commits;
        flushes = flush_count;
        commits = commit_count;
        issue_alu();
        issue_alu();
        issue_branch(op, equal, pred);
        issue_alu();
        issue_alu();
        issue_alu();
        stop_issue();
        while (flush_count == flushes)
            @(posedge clk);
        // anything younger than the branch must stay silent now
        repeat (6) @(posedge clk);
        check_value("flush count", 32'(flush_count - flushes), 32'd1);
        check_value("commit count", 32'(commit_count - commits), 32'd2);
        alu_burst(5);
    endtask

    initial begin
        void'($urandom(32'h7019_9404));
        rst          = 1'b1;
        issue_valid  = 1'b0;
        issue_op     = op_pkg::OP_ADD;
        issue_rd     = '0;
        issue_a      = '0;
        issue_b      = '0;
        issue_pred   = 1'b0;
        issue_target = '0;
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        alu_burst(12);
        fill_buffer();
        store_interleave();
        predicted_branches();
        mispredict_recovery(op_pkg::OP_BEQ, 1'b1, 1'b0);
        mispredict_recovery(op_pkg::OP_BNE, 1'b1, 1'b1);
        $display("errors: %0d, assertion failures: %0d", errors,
                 uut.u_rob.u_rob_chk.fail_count);
        if (errors == 0 && uut.u_rob.u_rob_chk.fail_count == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

/* bench/rob_chk.sv */
module rob_chk (
    input logic clk,
    input logic rst,
    input logic commit_en,
    input logic flush,
    input logic st_req,
    input logic alloc_en,
    input logic full
);

    int fail_count = 0;

    // the head either commits or flushes, never both
    commit_vs_flush: assert property (@(posedge clk) disable iff (rst) !(commit_en && flush))
        else begin
            $error("commit_en and flush high in the same cycle");
            fail_count++;
        end

    store_req_pulse: assert property (@(posedge clk) disable iff (rst) st_req |=> !st_req)
        else begin
            $error("st_req held longer than one cycle");
            fail_count++;
        end

    no_alloc_full: assert property (@(posedge clk) disable iff (rst) alloc_en |-> !full)
        else begin
            $error("entry allocated while the buffer is full");
            fail_count++;
        end

endmodule

bind rob rob_chk u_rob_chk (
    .clk      (clk),
    .rst      (rst),
    .commit_en(commit_en),
    .flush    (flush),
    .st_req   (st_req),
    .alloc_en (alloc_en),
    .full     (full)
);

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --assert -j 0 --top-module ooo_core_tb -f verilog.f

# let the bench finish its own report after an assertion error
out=$(./obj_dir/Vooo_core_tb +verilator+error+limit+100)
echo "$out"

echo "$out" | grep -qx "Test OK"

/* source/dispatch_stage.sv */
module dispatch_stage #(
    parameter int ROB_DEPTH = 8
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               flush,
    input  logic               issue_valid,
    input  op_pkg::op_t        issue_op,
    input  rob_pkg::reg_name_t issue_rd,
    input  rob_pkg::data_t     issue_a,
    input  rob_pkg::data_t     issue_b,
    input  logic               issue_pred,
    input  rob_pkg::addr_t     issue_target,
    input  logic               full,
    input  rob_pkg::tag_t      next_tag,
    output logic               issue_stall,
    output logic               alloc_en,
    output rob_pkg::tag_t      alloc_tag,
    output rob_pkg::reg_name_t alloc_rd,
    output logic               alloc_store,
    output logic               alloc_branch,
    output logic               alloc_pred,
    output logic               ex_in_valid,
    output rob_pkg::tag_t      ex_in_tag,
    output op_pkg::op_t        ex_in_op,
    output rob_pkg::data_t     ex_in_a,
    output rob_pkg::data_t     ex_in_b,
    output rob_pkg::addr_t     ex_in_target
);

    // keep tags inside the buffer range
    localparam rob_pkg::tag_t TAG_MASK = rob_pkg::tag_t'(ROB_DEPTH - 1);

    logic accept;

    assign issue_stall  = full;
    assign accept       = issue_valid && !full && !flush;

    // claim the tail entry in the same cycle the instruction is taken
    assign alloc_en     = accept;
    assign alloc_tag    = next_tag & TAG_MASK;
    assign alloc_rd     = issue_rd;
    assign alloc_store  = op_pkg::is_store(issue_op);
    assign alloc_branch = op_pkg::is_branch(issue_op);
    assign alloc_pred   = issue_pred;

    always_ff @(posedge clk) begin
        if (rst) begin
            ex_in_valid <= 1'b0;
        end else begin
            ex_in_valid <= accept;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            ex_in_tag    <= alloc_tag;
            ex_in_op     <= issue_op;
            ex_in_a      <= issue_a;
            ex_in_b      <= issue_b;
            ex_in_target <= issue_target;
        end
    end

endmodule

/* source/exec_unit.sv */
module exec_unit (
    input  logic           clk,
    input  logic           rst,
    input  logic           flush,
    input  logic           ex_in_valid,
    input  rob_pkg::tag_t  ex_in_tag,
    input  op_pkg::op_t    ex_in_op,
    input  rob_pkg::data_t ex_in_a,
    input  rob_pkg::data_t ex_in_b,
    input  rob_pkg::addr_t ex_in_target,
    output logic           done_en,
    output rob_pkg::tag_t  done_tag,
    output rob_pkg::data_t done_data,
    output logic           done_taken,
    output rob_pkg::addr_t done_addr
);

    logic           s1_valid;
    rob_pkg::tag_t  s1_tag;
    op_pkg::op_t    s1_op;
    logic           s1_branch;
    logic           s1_store;
    logic           s1_eq;
    rob_pkg::data_t s1_sum;
    rob_pkg::data_t s1_diff;
    rob_pkg::data_t s1_xor;
    rob_pkg::data_t s1_a;
    rob_pkg::data_t s1_b;
    rob_pkg::addr_t s1_target;
    logic           taken;

    // stage 1: decode and compute every candidate
    always_ff @(posedge clk) begin
        s1_tag    <= ex_in_tag;
        s1_op     <= ex_in_op;
        s1_branch <= op_pkg::is_branch(ex_in_op);
        s1_store  <= op_pkg::is_store(ex_in_op);
        s1_eq     <= ex_in_a == ex_in_b;
        s1_sum    <= ex_in_a + ex_in_b;
        s1_diff   <= ex_in_a - ex_in_b;
        s1_xor    <= ex_in_a ^ ex_in_b;
        s1_a      <= ex_in_a;
        s1_b      <= ex_in_b;
        s1_target <= ex_in_target;
    end

    // bne takes on inequality
    assign taken = s1_branch && ((s1_op == op_pkg::OP_BEQ) ? s1_eq : !s1_eq);

    // stage 2: pick result and address
    always_ff @(posedge clk) begin
        done_tag   <= s1_tag;
        done_taken <= taken;
        done_addr  <= '0;
        if (s1_store) begin
            done_data <= s1_b;
            done_addr <= s1_a;
        end else if (s1_branch) begin
            done_data <= '0;
            done_addr <= taken ? s1_target : s1_target + 32'd4;
        end else begin
            case (s1_op)
                op_pkg::OP_SUB: done_data <= s1_diff;
                op_pkg::OP_XOR: done_data <= s1_xor;
                default:        done_data <= s1_sum;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            s1_valid <= 1'b0;
            done_en  <= 1'b0;
        end else begin
            s1_valid <= ex_in_valid;
            done_en  <= s1_valid;
        end
    end

endmodule

/* source/ooo_core.sv */
module ooo_core #(
    parameter int ROB_DEPTH = 8
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               issue_valid,
    input  op_pkg::op_t        issue_op,
    input  rob_pkg::reg_name_t issue_rd,
    input  rob_pkg::data_t     issue_a,
    input  rob_pkg::data_t     issue_b,
    input  logic               issue_pred,
    input  rob_pkg::addr_t     issue_target,
    output logic               issue_stall,
    output logic               commit_en,
    output rob_pkg::reg_name_t commit_rd,
    output rob_pkg::data_t     commit_data,
    output rob_pkg::tag_t      commit_tag,
    output logic               flush,
    output rob_pkg::addr_t     flush_pc,
    output logic               mem_we,
    output rob_pkg::addr_t     mem_addr,
    output rob_pkg::data_t     mem_data
);

    // dispatch to rob
    logic               alloc_en;
    rob_pkg::tag_t      alloc_tag;
    rob_pkg::reg_name_t alloc_rd;
    logic               alloc_store;
    logic               alloc_branch;
    logic               alloc_pred;
    logic               full;
    rob_pkg::tag_t      next_tag;

    // dispatch to exec
    logic               ex_in_valid;
    rob_pkg::tag_t      ex_in_tag;
    op_pkg::op_t        ex_in_op;
    rob_pkg::data_t     ex_in_a;
    rob_pkg::data_t     ex_in_b;
    rob_pkg::addr_t     ex_in_target;

    // exec to rob
    logic               done_en;
    rob_pkg::tag_t      done_tag;
    rob_pkg::data_t     done_data;
    logic               done_taken;
    rob_pkg::addr_t     done_addr;

    // rob to store unit
    logic               st_req;
    rob_pkg::addr_t     st_addr;
    rob_pkg::data_t     st_data;
    logic               st_ack;

    dispatch_stage #(
        .ROB_DEPTH(ROB_DEPTH)
    ) u_dispatch (
        .clk         (clk),
        .rst         (rst),
        .flush       (flush),
        .issue_valid (issue_valid),
        .issue_op    (issue_op),
        .issue_rd    (issue_rd),
        .issue_a     (issue_a),
        .issue_b     (issue_b),
        .issue_pred  (issue_pred),
        .issue_target(issue_target),
        .full        (full),
        .next_tag    (next_tag),
        .issue_stall (issue_stall),
        .alloc_en    (alloc_en),
        .alloc_tag   (alloc_tag),
        .alloc_rd    (alloc_rd),
        .alloc_store (alloc_store),
        .alloc_branch(alloc_branch),
        .alloc_pred  (alloc_pred),
        .ex_in_valid (ex_in_valid),
        .ex_in_tag   (ex_in_tag),
        .ex_in_op    (ex_in_op),
        .ex_in_a     (ex_in_a),
        .ex_in_b     (ex_in_b),
        .ex_in_target(ex_in_target)
    );

    exec_unit u_exec (
        .clk         (clk),
        .rst         (rst),
        .flush       (flush),
        .ex_in_valid (ex_in_valid),
        .ex_in_tag   (ex_in_tag),
        .ex_in_op    (ex_in_op),
        .ex_in_a     (ex_in_a),
        .ex_in_b     (ex_in_b),
        .ex_in_target(ex_in_target),
        .done_en     (done_en),
        .done_tag    (done_tag),
        .done_data   (done_data),
        .done_taken  (done_taken),
        .done_addr   (done_addr)
    );

    rob #(
        .ROB_DEPTH(ROB_DEPTH)
    ) u_rob (
        .clk         (clk),
        .rst         (rst),
        .alloc_en    (alloc_en),
        .alloc_tag   (alloc_tag),
        .alloc_rd    (alloc_rd),
        .alloc_store (alloc_store),
        .alloc_branch(alloc_branch),
        .alloc_pred  (alloc_pred),
        .full        (full),
        .next_tag    (next_tag),
        .done_en     (done_en),
        .done_tag    (done_tag),
        .done_data   (done_data),
        .done_taken  (done_taken),
        .done_addr   (done_addr),
        .st_req      (st_req),
        .st_addr     (st_addr),
        .st_data     (st_data),
        .st_ack      (st_ack),
        .commit_en   (commit_en),
        .commit_rd   (commit_rd),
        .commit_data (commit_data),
        .commit_tag  (commit_tag),
        .flush       (flush),
        .flush_pc    (flush_pc)
    );

    // committed stores drain here, untouched by flush
    store_unit u_store (
        .clk     (clk),
        .rst     (rst),
        .st_req  (st_req),
        .st_addr (st_addr),
        .st_data (st_data),
        .st_ack  (st_ack),
        .mem_we  (mem_we),
        .mem_addr(mem_addr),
        .mem_data(mem_data)
    );

endmodule

/* source/op_pkg.sv */
package op_pkg;

    typedef logic [3:0] op_t;

    // alu group
    localparam op_t OP_ADD = 4'h0;
    localparam op_t OP_SUB = 4'h1;
    localparam op_t OP_XOR = 4'h2;

    // branch group, compare a against b
    localparam op_t OP_BEQ = 4'h8;
    localparam op_t OP_BNE = 4'h9;

    // store: address from a, data from b
    localparam op_t OP_SW  = 4'hc;

    function automatic logic is_store(op_t op);
        return op == OP_SW;
    endfunction

    function automatic logic is_branch(op_t op);
        return (op == OP_BEQ) || (op == OP_BNE);
    endfunction

endpackage

/* source/rob.sv */
module rob #(
    parameter int ROB_DEPTH = 8
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               alloc_en,
    input  rob_pkg::tag_t      alloc_tag,
    input  rob_pkg::reg_name_t alloc_rd,
    input  logic               alloc_store,
    input  logic               alloc_branch,
    input  logic               alloc_pred,
    output logic               full,
    output rob_pkg::tag_t      next_tag,
    input  logic               done_en,
    input  rob_pkg::tag_t      done_tag,
    input  rob_pkg::data_t     done_data,
    input  logic               done_taken,
    input  rob_pkg::addr_t     done_addr,
    output logic               st_req,
    output rob_pkg::addr_t     st_addr,
    output rob_pkg::data_t     st_data,
    input  logic               st_ack,
    output logic               commit_en,
    output rob_pkg::reg_name_t commit_rd,
    output rob_pkg::data_t     commit_data,
    output rob_pkg::tag_t      commit_tag,
    output logic               flush,
    output rob_pkg::addr_t     flush_pc
);

    localparam int PTR_W = $clog2(ROB_DEPTH);

    typedef enum logic {
        idle,
        wait_ack
    } state_t;

    state_t state;

    logic [PTR_W-1:0]     head;
    logic [PTR_W-1:0]     tail;
    logic [PTR_W-1:0]     alloc_idx;
    logic [PTR_W-1:0]     done_idx;
    logic [ROB_DEPTH-1:0] occupied;
    logic [ROB_DEPTH-1:0] done;

    // entry payload
    logic [ROB_DEPTH-1:0] ent_store;
    logic [ROB_DEPTH-1:0] ent_branch;
    logic [ROB_DEPTH-1:0] ent_pred;
    logic [ROB_DEPTH-1:0] ent_taken;
    rob_pkg::reg_name_t   ent_rd   [ROB_DEPTH];
    rob_pkg::data_t       ent_data [ROB_DEPTH];
    rob_pkg::addr_t       ent_addr [ROB_DEPTH];

    logic head_ready;
    logic branch_ok;
    logic store_done;
    logic retire;

    assign alloc_idx = alloc_tag[PTR_W-1:0];
    assign done_idx  = done_tag[PTR_W-1:0];

    assign full     = &occupied;
    assign next_tag = rob_pkg::tag_t'(tail);

    // head retirement decode
    assign head_ready = occupied[head] && done[head];
    assign commit_en  = head_ready && !ent_store[head] && !ent_branch[head];
    assign branch_ok  = head_ready && ent_branch[head] && (ent_pred[head] == ent_taken[head]);
    assign flush      = head_ready && ent_branch[head] && (ent_pred[head] != ent_taken[head]);
    assign st_req     = head_ready && ent_store[head] && (state == idle);
    assign store_done = (state == wait_ack) && st_ack;
    assign retire     = commit_en || branch_ok || store_done;

    assign commit_rd   = ent_rd[head];
    assign commit_data = ent_data[head];
    assign commit_tag  = rob_pkg::tag_t'(head);
    assign st_addr     = ent_addr[head];
    assign st_data     = ent_data[head];
    assign flush_pc    = ent_addr[head];

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            // mispredict drops every entry and restarts at 0
            occupied <= '0;
            done     <= '0;
            head     <= '0;
            tail     <= '0;
            state    <= idle;
        end else begin
            if (alloc_en) begin
                occupied[alloc_idx] <= 1'b1;
                done[alloc_idx]     <= 1'b0;
                tail                <= tail + 1'b1;
            end
            if (done_en) begin
                done[done_idx] <= 1'b1;
            end
            if (retire) begin
                occupied[head] <= 1'b0;
                head           <= head + 1'b1;
            end
            case (state)
                idle: begin
                    if (st_req) begin
                        state <= wait_ack;
                    end
                end
                wait_ack: begin
                    if (st_ack) begin
                        state <= idle;
                    end
                end
                default: state <= idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (alloc_en) begin
            ent_store[alloc_idx]  <= alloc_store;
            ent_branch[alloc_idx] <= alloc_branch;
            ent_pred[alloc_idx]   <= alloc_pred;
            ent_rd[alloc_idx]     <= alloc_rd;
        end
        // completions land by tag in any order
        if (done_en) begin
            ent_data[done_idx]  <= done_data;
            ent_taken[done_idx] <= done_taken;
            ent_addr[done_idx]  <= done_addr;
        end
    end

endmodule

/* source/rob_pkg.sv */
package rob_pkg;

    // tag width covers up to 32 buffer entries
    localparam int TAG_W  = 5;
    localparam int REG_W  = 5;
    localparam int DATA_W = 32;
    localparam int ADDR_W = 32;

    // reorder-buffer entry index
    typedef logic [TAG_W-1:0] tag_t;

    // architectural destination register
    typedef logic [REG_W-1:0] reg_name_t;

    typedef logic [DATA_W-1:0] data_t;

    // memory and branch target addresses
    typedef logic [ADDR_W-1:0] addr_t;

endpackage

/* source/store_unit.sv */
module store_unit (
    input  logic           clk,
    input  logic           rst,
    input  logic           st_req,
    input  rob_pkg::addr_t st_addr,
    input  rob_pkg::data_t st_data,
    output logic           st_ack,
    output logic           mem_we,
    output rob_pkg::addr_t mem_addr,
    output rob_pkg::data_t mem_data
);

    logic pending;

    // one request in flight, the write lands the cycle after st_req
    always_ff @(posedge clk) begin
        if (rst) begin
            pending <= 1'b0;
        end else begin
            pending <= st_req && !pending;
        end
    end

    // committed store, held for the memory write
    always_ff @(posedge clk) begin
        if (st_req && !pending) begin
            mem_addr <= st_addr;
            mem_data <= st_data;
        end
    end

    assign mem_we = pending;

    // ack goes back with the write itself
    assign st_ack = pending;

endmodule

/* verilog.f */
source/rob_pkg.sv
source/op_pkg.sv
source/dispatch_stage.sv
source/exec_unit.sv
source/rob.sv
source/store_unit.sv
source/ooo_core.sv
bench/rob_chk.sv
bench/ooo_core_tb.sv
